// ==== Makefile ====
TOP := tb_cgra

sim:
	verilator --binary -sv -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== cgra_cfg_pkg.sv ====
// ====================================================================
// Fabric and context frame definitions for the CGRA control plane
// Imported by the loader, context store, sequencer and top level
// ====================================================================
`default_nettype none

package cgra_cfg_pkg;

    // Fabric size, one context frame per PE
    localparam int NUM_PES      = 16;
    localparam int CONFIG_WIDTH = 64;

    // Frames sit back to back in configuration memory
    localparam int FRAME_BYTES  = CONFIG_WIDTH / 8;

    typedef logic [3:0]              pe_idx_t;
    typedef logic [CONFIG_WIDTH-1:0] frame_t;
    typedef logic [31:0]             cfg_addr_t;

    // Bitstream length in frames
    typedef logic [15:0]             frame_cnt_t;

    // Run length in timesteps
    typedef logic [15:0]             timestep_t;

endpackage

`default_nettype wire

// ==== cgra_config_loader.sv ====
// ====================================================================
// Configuration loader: fetches bitstream frames one at a time from
// configuration memory and writes them into the shadow context bank
// ====================================================================
`default_nettype none

module cgra_config_loader
    import cgra_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_start,
    input  cfg_addr_t  bs_addr,
    input  frame_cnt_t bs_size,
    input  logic       cfg_mem_valid,
    input  frame_t     cfg_mem_rdata,
    output cfg_addr_t  cfg_mem_addr,
    output logic       cfg_mem_read,
    output logic       frame_we,
    output pe_idx_t    frame_idx,
    output frame_t     frame_data,
    output logic       load_done,
    output logic       load_error
);

    typedef enum logic {
        LD_IDLE,
        LD_FETCH
    } ld_state_t;

    ld_state_t state;
    // Index of the frame now outstanding
    pe_idx_t   idx;
    pe_idx_t   last_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= LD_IDLE;
            idx          <= '0;
            last_idx     <= '0;
            cfg_mem_addr <= '0;
            cfg_mem_read <= 1'b0;
            frame_we     <= 1'b0;
            frame_idx    <= '0;
            load_done    <= 1'b0;
            load_error   <= 1'b0;
        end else begin
            cfg_mem_read <= 1'b0;
            frame_we     <= 1'b0;
            load_done    <= 1'b0;
            load_error   <= 1'b0;

            case (state)
                LD_IDLE: begin
                    if (load_start) begin
                        if (bs_size == '0 || bs_size > frame_cnt_t'(NUM_PES)) begin
                            load_error <= 1'b1;
                        end else begin
                            // First request goes out right away
                            idx          <= '0;
                            last_idx     <= pe_idx_t'(bs_size - frame_cnt_t'(1));
                            cfg_mem_addr <= bs_addr;
                            cfg_mem_read <= 1'b1;
                            state        <= LD_FETCH;
                        end
                    end
                end

                LD_FETCH: begin
                    // Wait as long as the memory needs, no timeout
                    if (cfg_mem_valid) begin
                        frame_we  <= 1'b1;
                        frame_idx <= idx;
                        if (idx == last_idx) begin
                            load_done <= 1'b1;
                            state     <= LD_IDLE;
                        end else begin
                            idx          <= idx + pe_idx_t'(1);
                            cfg_mem_addr <= cfg_mem_addr + cfg_addr_t'(FRAME_BYTES);
                            cfg_mem_read <= 1'b1;
                        end
                    end
                end

                default: state <= LD_IDLE;
            endcase
        end
    end

    // Returned frame, held for the write cycle
    always_ff @(posedge clk) begin
        if (state == LD_FETCH && cfg_mem_valid) begin
            frame_data <= cfg_mem_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== cgra_context_buffer.sv ====
// ====================================================================
// Double-buffered context store: loads fill the inactive bank, a swap
// makes it active, and one frame of the active bank is read out
// ====================================================================
`default_nettype none

module cgra_context_buffer
    import cgra_cfg_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    frame_we,
    input  pe_idx_t frame_idx,
    input  frame_t  frame_data,
    input  logic    ctx_swap,
    input  pe_idx_t ctx_sel,
    output logic    active_buf,
    output frame_t  ctx_frame
);

    // Bank 0 and bank 1, one frame per PE each
    frame_t ctx_mem [0:1][0:NUM_PES-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_buf <= 1'b0;
        end else if (ctx_swap) begin
            active_buf <= ~active_buf;
        end
    end

    // Shadow bank only
    always_ff @(posedge clk) begin
        if (frame_we) begin
            ctx_mem[~active_buf][frame_idx] <= frame_data;
        end
    end

    // Host readback; a PE array would tap the active bank the same way
    assign ctx_frame = ctx_mem[active_buf][ctx_sel];

endmodule

`default_nettype wire

// ==== cgra_csr_regs.sv ====
// ====================================================================
// Host register block: writable config, command pulses, sticky status,
// registered read port and masked interrupt pulse
// ====================================================================
`default_nettype none

module cgra_csr_regs
    import cgra_cfg_pkg::*, cgra_reg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       reg_wr,
    input  logic       reg_rd,
    input  reg_addr_t  reg_addr,
    input  reg_data_t  reg_wdata,
    input  logic       busy,
    input  logic       run_done,
    input  logic       run_error,
    input  logic       cfg_done,
    input  logic       active_buf,
    input  reg_data_t  perf_cycles,
    input  frame_t     ctx_frame,
    output reg_data_t  reg_rdata,
    output logic       reg_rvalid,
    output logic       run_start,
    output logic       cfg_start,
    output cfg_addr_t  bs_addr,
    output frame_cnt_t bs_size,
    output timestep_t  run_len,
    output pe_idx_t    ctx_sel,
    output logic       irq
);

    irq_mask_t irq_mask;
    logic      st_done;
    logic      st_error;
    logic      st_cfg_done;
    logic      cmd_wr;
    reg_data_t status_word;
    reg_data_t rd_word;

    // Any command write clears the sticky bits
    assign cmd_wr = reg_wr && (reg_addr == REG_CTRL) &&
                    (reg_wdata[CTRL_START] || reg_wdata[CTRL_CFG_START]);

    // ================================================================
    // Write side
    // ================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bs_addr   <= '0;
            bs_size   <= '0;
            run_len   <= '0;
            ctx_sel   <= '0;
            irq_mask  <= '0;
            run_start <= 1'b0;
            cfg_start <= 1'b0;
        end else begin
            // Command bits only live for one cycle
            run_start <= 1'b0;
            cfg_start <= 1'b0;
            if (reg_wr) begin
                case (reg_addr)
                    REG_CTRL: begin
                        run_start <= reg_wdata[CTRL_START];
                        cfg_start <= reg_wdata[CTRL_CFG_START];
                    end
                    REG_BS_ADDR:  bs_addr  <= reg_wdata;
                    REG_BS_SIZE:  bs_size  <= frame_cnt_t'(reg_wdata);
                    REG_IRQ_MASK: irq_mask <= irq_mask_t'(reg_wdata);
                    REG_RUN_LEN:  run_len  <= timestep_t'(reg_wdata);
                    REG_CTX_SEL:  ctx_sel  <= pe_idx_t'(reg_wdata);
                    default: ;
                endcase
            end
        end
    end

    // Sticky event bits, a same-cycle event beats the clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st_done     <= 1'b0;
            st_error    <= 1'b0;
            st_cfg_done <= 1'b0;
        end else begin
            st_done     <= (st_done & ~cmd_wr) | run_done;
            st_error    <= (st_error & ~cmd_wr) | run_error;
            st_cfg_done <= (st_cfg_done & ~cmd_wr) | cfg_done;
        end
    end

    // ================================================================
    // Read side
    // ================================================================
    always_comb begin
        status_word                = '0;
        status_word[ST_BUSY]       = busy;
        status_word[ST_DONE]       = st_done;
        status_word[ST_ERROR]      = st_error;
        status_word[ST_CFG_DONE]   = st_cfg_done;
        status_word[ST_ACTIVE_BUF] = active_buf;
    end

    // CTRL is write-only, unmapped offsets fall to zero
    always_comb begin
        case (reg_addr)
            REG_STATUS:      rd_word = status_word;
            REG_BS_ADDR:     rd_word = bs_addr;
            REG_BS_SIZE:     rd_word = reg_data_t'(bs_size);
            REG_IRQ_MASK:    rd_word = reg_data_t'(irq_mask);
            REG_RUN_LEN:     rd_word = reg_data_t'(run_len);
            REG_PERF_CYCLES: rd_word = perf_cycles;
            REG_CTX_SEL:     rd_word = reg_data_t'(ctx_sel);
            REG_CTX_LO:      rd_word = ctx_frame[31:0];
            REG_CTX_HI:      rd_word = ctx_frame[CONFIG_WIDTH-1:32];
            default:         rd_word = '0;
        endcase
    end

    // Data returns the cycle after the strobe
    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_rvalid <= 1'b0;
            irq        <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
            irq        <= (irq_mask[IRQ_DONE] & run_done) |
                          (irq_mask[IRQ_ERROR] & run_error) |
                          (irq_mask[IRQ_CFG_DONE] & cfg_done);
        end
    end

endmodule

`default_nettype wire

// ==== cgra_reg_pkg.sv ====
// ====================================================================
// Host register map of the CGRA control plane
// Byte offsets, CTRL/STATUS bit positions and interrupt mask bits
// ====================================================================
`default_nettype none

package cgra_reg_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Register byte offsets
    localparam reg_addr_t REG_CTRL        = 8'h00;
    localparam reg_addr_t REG_STATUS      = 8'h04;
    localparam reg_addr_t REG_BS_ADDR     = 8'h08;
    localparam reg_addr_t REG_BS_SIZE     = 8'h0C;
    localparam reg_addr_t REG_IRQ_MASK    = 8'h10;
    localparam reg_addr_t REG_RUN_LEN     = 8'h14;
    localparam reg_addr_t REG_PERF_CYCLES = 8'h18;
    localparam reg_addr_t REG_CTX_SEL     = 8'h1C;
    localparam reg_addr_t REG_CTX_LO      = 8'h20;
    localparam reg_addr_t REG_CTX_HI      = 8'h24;

    // CTRL command bits, write-only strobes
    localparam int CTRL_START     = 0;
    localparam int CTRL_CFG_START = 1;

    // STATUS bits
    localparam int ST_BUSY       = 0;
    localparam int ST_DONE       = 1;
    localparam int ST_ERROR      = 2;
    localparam int ST_CFG_DONE   = 3;
    localparam int ST_ACTIVE_BUF = 4;

    // IRQ_MASK bits
    localparam int IRQ_DONE     = 0;
    localparam int IRQ_ERROR    = 1;
    localparam int IRQ_CFG_DONE = 2;

    typedef logic [IRQ_CFG_DONE:0] irq_mask_t;

endpackage

`default_nettype wire

// ==== cgra_sequencer.sv ====
// ====================================================================
// Command sequencer: runs configuration loads and timed runs, swaps
// the context banks after a good load, reports events as pulses
// ====================================================================
`default_nettype none

module cgra_sequencer
    import cgra_cfg_pkg::*, cgra_reg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run_start,
    input  logic      cfg_start,
    input  timestep_t run_len,
    input  logic      load_done,
    input  logic      load_error,
    output logic      load_start,
    output logic      ctx_swap,
    output logic      fabric_enable,
    output logic      busy,
    output logic      run_done,
    output logic      run_error,
    output logic      cfg_done,
    output reg_data_t perf_cycles
);

    typedef enum logic [1:0] {
        IDLE,
        LOADING,
        RUNNING
    } seq_state_t;

    seq_state_t state;
    logic       loaded;
    // Timesteps still to go in the current run
    timestep_t  ts_left;

    assign busy          = (state != IDLE);
    assign fabric_enable = (state == RUNNING);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            loaded      <= 1'b0;
            ts_left     <= '0;
            perf_cycles <= '0;
            load_start  <= 1'b0;
            ctx_swap    <= 1'b0;
            run_done    <= 1'b0;
            run_error   <= 1'b0;
            cfg_done    <= 1'b0;
        end else begin
            load_start <= 1'b0;
            ctx_swap   <= 1'b0;
            run_done   <= 1'b0;
            run_error  <= 1'b0;
            cfg_done   <= 1'b0;

            case (state)
                IDLE: begin
                    // A load request takes priority over a run
                    if (cfg_start) begin
                        load_start <= 1'b1;
                        state      <= LOADING;
                    end else if (run_start) begin
                        if (!loaded || run_len == '0) begin
                            run_error <= 1'b1;
                        end else begin
                            ts_left     <= run_len;
                            perf_cycles <= '0;
                            state       <= RUNNING;
                        end
                    end
                end

                LOADING: begin
                    if (load_done) begin
                        ctx_swap <= 1'b1;
                        cfg_done <= 1'b1;
                        loaded   <= 1'b1;
                        state    <= IDLE;
                    end else if (load_error) begin
                        // Rejected bitstream, banks untouched
                        run_error <= 1'b1;
                        state     <= IDLE;
                    end
                end

                RUNNING: begin
                    // One timestep per enabled cycle
                    perf_cycles <= perf_cycles + reg_data_t'(1);
                    ts_left     <= ts_left - timestep_t'(1);
                    if (ts_left == timestep_t'(1)) begin
                        run_done <= 1'b1;
                        state    <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== cgra_tests.txt ====
# M addr data | W offset data | R offset expected | P bit value max_reads
# F base_addr frames | T name irq_pulses enable_cycles ; numbers in hex
R 04 00000000
R 10 00000000
R 14 00000000
T reset 0 0
W 10 2
W 14 5
W 00 1
P 2 1 10
R 04 00000004
T noload 1 0
W 10 4
W 08 00000100
W 0C 10
W 00 2
P 3 1 60
R 04 00000018
F 00000100 10
T load16 1 0
M 400 0123456789ABCDEF
M 408 FEDCBA9876543210
M 410 A5A5A5A55A5A5A5A
M 418 0F0F0F0FF0F0F0F0
W 08 00000400
W 0C 4
W 00 2
P 3 1 20
R 04 00000008
F 00000400 4
T load4 1 0
W 10 2
W 0C 0
W 00 2
P 2 1 10
R 04 00000004
W 10 0
W 0C 11
W 00 2
P 2 1 10
R 04 00000004
T badsize 1 0
W 10 1
W 14 25
W 00 1
P 1 1 40
R 04 00000002
R 18 00000025
T run 1 25
W 10 2
W 14 0
W 00 1
P 2 1 10
R 04 00000004
T zerolen 1 0

// ==== cgra_top.sv ====
// ====================================================================
// CGRA control plane top level: register block, sequencer,
// configuration loader and double-buffered context store
// ====================================================================
`default_nettype none

module cgra_top
    import cgra_cfg_pkg::*, cgra_reg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Host register bus
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    output reg_data_t reg_rdata,
    output logic      reg_rvalid,
    // Configuration memory port
    output cfg_addr_t cfg_mem_addr,
    output logic      cfg_mem_read,
    input  logic      cfg_mem_valid,
    input  frame_t    cfg_mem_rdata,
    // Fabric and host interrupt
    output logic      fabric_enable,
    output logic      irq
);

    // ================================================================
    // Internal wiring
    // ================================================================
    logic       run_start;
    logic       cfg_start;
    cfg_addr_t  bs_addr;
    frame_cnt_t bs_size;
    timestep_t  run_len;
    pe_idx_t    ctx_sel;
    logic       busy;
    logic       run_done;
    logic       run_error;
    logic       cfg_done;
    reg_data_t  perf_cycles;
    logic       load_start;
    logic       load_done;
    logic       load_error;
    logic       ctx_swap;
    logic       frame_we;
    pe_idx_t    frame_idx;
    frame_t     frame_data;
    logic       active_buf;
    frame_t     ctx_frame;

    cgra_csr_regs u_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .busy        (busy),
        .run_done    (run_done),
        .run_error   (run_error),
        .cfg_done    (cfg_done),
        .active_buf  (active_buf),
        .perf_cycles (perf_cycles),
        .ctx_frame   (ctx_frame),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid),
        .run_start   (run_start),
        .cfg_start   (cfg_start),
        .bs_addr     (bs_addr),
        .bs_size     (bs_size),
        .run_len     (run_len),
        .ctx_sel     (ctx_sel),
        .irq         (irq)
    );

    cgra_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .run_start     (run_start),
        .cfg_start     (cfg_start),
        .run_len       (run_len),
        .load_done     (load_done),
        .load_error    (load_error),
        .load_start    (load_start),
        .ctx_swap      (ctx_swap),
        .fabric_enable (fabric_enable),
        .busy          (busy),
        .run_done      (run_done),
        .run_error     (run_error),
        .cfg_done      (cfg_done),
        .perf_cycles   (perf_cycles)
    );

    cgra_config_loader u_loader (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_start    (load_start),
        .bs_addr       (bs_addr),
        .bs_size       (bs_size),
        .cfg_mem_valid (cfg_mem_valid),
        .cfg_mem_rdata (cfg_mem_rdata),
        .cfg_mem_addr  (cfg_mem_addr),
        .cfg_mem_read  (cfg_mem_read),
        .frame_we      (frame_we),
        .frame_idx     (frame_idx),
        .frame_data    (frame_data),
        .load_done     (load_done),
        .load_error    (load_error)
    );

    cgra_context_buffer u_ctx (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_we   (frame_we),
        .frame_idx  (frame_idx),
        .frame_data (frame_data),
        .ctx_swap   (ctx_swap),
        .ctx_sel    (ctx_sel),
        .active_buf (active_buf),
        .ctx_frame  (ctx_frame)
    );

endmodule

`default_nettype wire

// ==== flist.f ====
cgra_cfg_pkg.sv
cgra_reg_pkg.sv
cgra_csr_regs.sv
cgra_sequencer.sv
cgra_config_loader.sv
cgra_context_buffer.sv
cgra_top.sv
tb_cgra.sv

// ==== tb_cgra.sv ====
// ======================================================================
// Testbench for the CGRA control plane
// Runs the script in cgra_tests.txt against cgra_top
// Configuration memory model with random read latency
// ======================================================================
`default_nettype none

module tb_cgra
    import cgra_cfg_pkg::*, cgra_reg_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS  = 256;
    localparam int RD_TIMEOUT = 8;
    // Byte step between 64-bit words of the configuration memory
    localparam int WORD_BYTES = 8;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      reg_wr;
    logic      reg_rd;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;
    logic      reg_rvalid;
    cfg_addr_t cfg_mem_addr;
    logic      cfg_mem_read;
    logic      cfg_mem_valid = 1'b0;
    frame_t    cfg_mem_rdata = '0;
    logic      fabric_enable;
    logic      irq;

    // Memory model state
    frame_t      cfg_mem [0:MEM_WORDS-1];
    logic        mem_pending = 1'b0;
    int          mem_delay = 0;
    cfg_addr_t   mem_addr_q = '0;
    logic [15:0] lfsr = 16'd69;
    logic [1:0]  lat_bits;

    // Monitors and score
    int irq_count = 0;
    int en_count = 0;
    int irq_base = 0;
    int en_base = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    always #20 clk = ~clk;

    cgra_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .reg_rvalid    (reg_rvalid),
        .cfg_mem_addr  (cfg_mem_addr),
        .cfg_mem_read  (cfg_mem_read),
        .cfg_mem_valid (cfg_mem_valid),
        .cfg_mem_rdata (cfg_mem_rdata),
        .fabric_enable (fabric_enable),
        .irq           (irq)
    );

    // ==================================================================
    // Helper functions
    // ==================================================================
    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // Word slot of a byte address in the memory model
    function automatic logic [7:0] mem_index(input cfg_addr_t a);
        return a[10:3];
    endfunction

    // Background content that depends on every address bit
    function automatic frame_t fill_word(input cfg_addr_t a);
        return {a ^ 32'hC6A0_0000, a * 32'h9E37_79B9 + 32'h1};
    endfunction

    // ==================================================================
    // Configuration memory model with one read in flight
    // ==================================================================
    always @(posedge clk) begin
        cfg_mem_valid <= 1'b0;
        if (!rst_n) begin
            mem_pending <= 1'b0;
        end else if (mem_pending) begin
            if (mem_delay == 1) begin
                cfg_mem_valid <= 1'b1;
                cfg_mem_rdata <= cfg_mem[mem_index(mem_addr_q)];
                mem_pending   <= 1'b0;
            end else begin
                mem_delay <= mem_delay - 1;
            end
        end else if (cfg_mem_read) begin
            // Latency of 1 to 4 cycles from one LFSR step per bit
            lfsr        = lfsr_step(lfsr);
            lat_bits[0] = lfsr[0];
            lfsr        = lfsr_step(lfsr);
            lat_bits[1] = lfsr[0];
            mem_delay   <= int'(lat_bits) + 1;
            mem_addr_q  <= cfg_mem_addr;
            mem_pending <= 1'b1;
        end
    end

    // Pulse and enable counters over the whole simulation
    always @(posedge clk) begin
        if (rst_n && irq) begin
            irq_count <= irq_count + 1;
        end
        if (rst_n && fabric_enable) begin
            en_count <= en_count + 1;
        end
    end

    // ==================================================================
    // Bus tasks and checks
    // ==================================================================
    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic reg_write(input reg_addr_t a, input reg_data_t d);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= a;
        reg_wdata <= d;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    // Data is sampled on the falling edge while reg_rvalid is high
    task automatic reg_read(input reg_addr_t a, output reg_data_t d, output bit ok);
        int n;
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= a;
        @(posedge clk);
        reg_rd   <= 1'b0;
        n  = 0;
        ok = 1'b0;
        d  = '0;
        while (!ok && n < RD_TIMEOUT) begin
            @(negedge clk);
            if (reg_rvalid) begin
                ok = 1'b1;
                d  = reg_rdata;
            end
            n++;
        end
        if (!ok) begin
            $display("Register read at offset %h got no response", a);
            errors++;
            test_errors++;
        end
    endtask

    task automatic poll_status(input int bit_pos, input logic val, input int limit);
        reg_data_t d;
        bit        ok;
        bit        hit;
        int        n;
        hit = 1'b0;
        n   = 0;
        while (!hit && n < limit) begin
            reg_read(REG_STATUS, d, ok);
            if (ok && d[bit_pos] == val) begin
                hit = 1'b1;
            end
            n++;
        end
        if (!hit) begin
            $display("Status bit %0d did not reach %0d within %0d reads", bit_pos, val, limit);
            errors++;
            test_errors++;
        end
    endtask

    // Active context against the memory image it was loaded from
    task automatic check_frames(input cfg_addr_t base, input int count);
        reg_data_t lo;
        reg_data_t hi;
        bit        ok;
        frame_t    exp;
        int        i;
        for (i = 0; i < count; i++) begin
            // Frame i sits 8 bytes per index above the base
            exp = cfg_mem[mem_index(base + cfg_addr_t'(i * WORD_BYTES))];
            reg_write(REG_CTX_SEL, reg_data_t'(i));
            reg_read(REG_CTX_LO, lo, ok);
            if (ok) begin
                check_value($sformatf("frame %0d low word", i), 64'(lo), 64'(exp[31:0]));
            end
            reg_read(REG_CTX_HI, hi, ok);
            if (ok) begin
                check_value($sformatf("frame %0d high word", i), 64'(hi), 64'(exp[63:32]));
            end
        end
    endtask

    task automatic finish_test(input string name, input int exp_irq, input int exp_en);
        @(negedge clk);
        check_value("irq pulses", 64'(irq_count - irq_base), 64'(exp_irq));
        check_value("fabric enable cycles", 64'(en_count - en_base), 64'(exp_en));
        $display("test %-8s done, %0d errors", name, test_errors);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_errors = 0;
        irq_base    = irq_count;
        en_base     = en_count;
    endtask

    // ==================================================================
    // Script interpreter
    // ==================================================================
    initial begin
        int          fd;
        int          i;
        string       line;
        string       cmd;
        string       name;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        reg_data_t   d;
        bit          ok;

        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        for (i = 0; i < MEM_WORDS; i++) begin
            cfg_mem[i] = fill_word(cfg_addr_t'(i * WORD_BYTES));
        end

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("cgra_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test script cgra_tests.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                a = '0;
                b = '0;
                c = '0;
                void'($sscanf(line, "%s", cmd));
                if (cmd == "T") begin
                    void'($sscanf(line, "%s %s %h %h", cmd, name, a, b));
                    finish_test(name, int'(a), int'(b));
                end else begin
                    void'($sscanf(line, "%s %h %h %h", cmd, a, b, c));
                    if (cmd == "M") begin
                        cfg_mem[mem_index(cfg_addr_t'(a))] = frame_t'(b);
                    end else if (cmd == "W") begin
                        reg_write(reg_addr_t'(a), reg_data_t'(b));
                    end else if (cmd == "R") begin
                        reg_read(reg_addr_t'(a), d, ok);
                        if (ok) begin
                            check_value($sformatf("read offset %h", a[7:0]), 64'(d), b);
                        end
                    end else if (cmd == "P") begin
                        poll_status(int'(a), b[0], int'(c));
                    end else if (cmd == "F") begin
                        check_frames(cfg_addr_t'(a), int'(b));
                    end else begin
                        $display("Unknown command in the test script: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
